/* verilog/read_engine_pkg.sv */
`default_nettype none

package read_engine_pkg;

  // --------------------
  // Bus and word widths
  // --------------------
  localparam int dq_width   = 8;   // Octal memory data bus
  localparam int word_width = 16;  // One FIFO entry, two bytes

  // --------------------
  // FIFO sizing
  // --------------------
  localparam int rcv_fifo_addr_width = 4;  // 16 entries
  localparam int stretch_margin      = 2;  // Free entries that trigger stretch

  // Programmed counts
  localparam int byte_cnt_width = 6;  // Data read length in bytes
  localparam int dlp_cnt_width  = 3;  // DLP words minus one

  // Receiver ownership of the FIFO read port
  typedef enum logic [1:0] {
    st_idle,   // Nobody reads
    st_train,  // Training monitor reads
    st_data    // Data block reads
  } rcvr_state_t;

endpackage

`default_nettype wire

/* verilog/rcv_dq_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rcv_dq_fifo #(
  parameter int addr_width = read_engine_pkg::rcv_fifo_addr_width
) (
  input  wire                                   mem_clk,
  input  wire                                   reset,
  input  wire                                   dqs,          // Strobe level from memory
  input  wire  [read_engine_pkg::dq_width-1:0]  dq_in,
  input  wire                                   rd_en,        // Pop head word
  input  wire                                   flush_en,
  output logic [read_engine_pkg::word_width-1:0] dout,        // Head word, fall through
  output logic                                  empty,
  output logic                                  almost_full,
  output logic                                  flush_done
);

  import read_engine_pkg::*;

  localparam int depth = 1 << addr_width;

  // Storage
  logic [word_width-1:0] mem [depth];
  logic [addr_width-1:0] wr_ptr;
  logic [addr_width-1:0] rd_ptr;
  logic [addr_width:0]   count;      // One bit wider than the pointers
  logic [addr_width:0]   free_cnt;
  logic                  full;

  // Capture side
  logic                  dqs_q;
  logic                  dqs_edge;
  logic                  byte_held;  // High byte waiting for its partner
  logic [dq_width-1:0]   hi_byte;
  logic                  push;
  logic                  pop;

  // --------------------
  // Byte capture
  // --------------------
  assign dqs_edge = dqs ^ dqs_q;                    // Either edge carries a byte
  assign push     = dqs_edge && byte_held && !flush_en;
  assign pop      = rd_en && !empty && !flush_en;

  always_ff @(posedge mem_clk) begin
    if (reset) begin
      dqs_q     <= 1'b0;
      byte_held <= 1'b0;
    end else begin
      dqs_q <= dqs;
      if (flush_en) begin
        byte_held <= 1'b0;                          // Drop any odd byte
      end else if (dqs_edge) begin
        byte_held <= !byte_held;
      end
    end
  end

  // First byte of a pair goes high
  always_ff @(posedge mem_clk) begin
    if (dqs_edge && !byte_held) begin
      hi_byte <= dq_in;
    end
  end

  // --------------------
  // Circular buffer
  // --------------------
  always_ff @(posedge mem_clk) begin
    if (push) begin
      mem[wr_ptr] <= {hi_byte, dq_in};              // Second byte completes the word
    end
  end

  always_ff @(posedge mem_clk) begin
    if (reset || flush_en) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;                    // Wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                    // Idle or both
      endcase
    end
  end

  // Flush acknowledge, one cycle behind the request
  always_ff @(posedge mem_clk) begin
    if (reset) begin
      flush_done <= 1'b0;
    end else begin
      flush_done <= flush_en;
    end
  end

  // Status
  assign dout        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == (addr_width + 1)'(depth));
  assign free_cnt    = (addr_width + 1)'(depth) - count;
  assign almost_full = (free_cnt <= (addr_width + 1)'(stretch_margin));

  // Stretch request must pause the memory before the buffer overflows
  a_no_push_full : assert property (
    @(posedge mem_clk) disable iff (reset) (push && full) |-> pop
  ) else $error("rcv_dq_fifo: byte pair pushed into a full FIFO");

  // Clients only pop what is there
  a_no_pop_empty : assert property (
    @(posedge mem_clk) disable iff (reset) !(rd_en && empty)
  ) else $error("rcv_dq_fifo: pop requested while FIFO is empty");

endmodule

`default_nettype wire

/* verilog/training_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module training_monitor (
  input  wire                                     mem_clk,
  input  wire                                     reset,
  input  wire                                     blk_en,        // Grant from rcvr_fsm
  input  wire  [read_engine_pkg::dq_width-1:0]    dlp_pattern,   // Expected byte on every beat
  input  wire  [read_engine_pkg::dlp_cnt_width-1:0] dlp_cyc_cnt, // Words to check, minus one
  input  wire                                     fifo_empty,
  input  wire  [read_engine_pkg::word_width-1:0]  fifo_dout,
  output logic                                    rd_en,
  output logic [read_engine_pkg::dq_width-1:0]    calib_tap_out, // One bit per dq lane
  output logic                                    calib_tap_valid,
  output logic                                    dlp_read_stop
);

  import read_engine_pkg::*;

  logic                     blk_en_q;
  logic                     start;
  logic                     active;     // Still collecting pattern words
  logic [dlp_cnt_width-1:0] word_cnt;
  logic                     last_pop;
  logic [dq_width-1:0]      lane_mask;  // Lanes that matched so far
  logic [dq_width-1:0]      hi_err;
  logic [dq_width-1:0]      lo_err;

  // --------------------
  // Sequencing
  // --------------------
  assign start    = blk_en && !blk_en_q;             // Grant just arrived
  assign rd_en    = blk_en && active && !fifo_empty;
  assign last_pop = rd_en && (word_cnt == dlp_cyc_cnt);

  always_ff @(posedge mem_clk) begin
    if (reset) begin
      blk_en_q <= 1'b0;
      active   <= 1'b0;
      word_cnt <= '0;
    end else begin
      blk_en_q <= blk_en;
      if (start) begin
        active   <= 1'b1;
        word_cnt <= '0;
      end else if (rd_en) begin
        word_cnt <= word_cnt + 1'b1;
        if (last_pop) begin
          active <= 1'b0;                            // Count reached
        end
      end
    end
  end

  // --------------------
  // Lane comparison
  // --------------------
  // Both bytes of a word are checked against the same pattern
  assign hi_err = fifo_dout[word_width-1 -: dq_width] ^ dlp_pattern;
  assign lo_err = fifo_dout[dq_width-1:0] ^ dlp_pattern;

  always_ff @(posedge mem_clk) begin
    if (reset) begin
      lane_mask <= '1;
    end else if (start) begin
      lane_mask <= '1;                               // All lanes pass until proven bad
    end else if (rd_en) begin
      lane_mask <= lane_mask & ~(hi_err | lo_err);   // A mismatch sticks
    end
  end

  assign calib_tap_out = lane_mask;                  // Final after last pop

  // Result strobes, one cycle after the last pop
  always_ff @(posedge mem_clk) begin
    if (reset) begin
      calib_tap_valid <= 1'b0;
      dlp_read_stop   <= 1'b0;
    end else begin
      calib_tap_valid <= last_pop;
      dlp_read_stop   <= last_pop;
    end
  end

endmodule

`default_nettype wire

/* verilog/rxdata_blk.sv */
`timescale 1ns/1ps
`default_nettype none

module rxdata_blk (
  input  wire                                        mem_clk,
  input  wire                                        reset,
  input  wire                                        blk_en,
  input  wire  [read_engine_pkg::byte_cnt_width-1:0] no_of_data_bytes,
  input  wire                                        fifo_empty,
  input  wire                                        fifo_almost_full,
  input  wire  [read_engine_pkg::word_width-1:0]     fifo_dout,
  input  wire                                        rdata_ack,      // Host side of handshake
  output logic                                       rd_en,
  output logic [read_engine_pkg::word_width-1:0]     rdata,
  output logic                                       rdata_valid,
  output logic                                       read_end,
  output logic                                       rd_clk_stretch
);

  import read_engine_pkg::*;

  logic                      blk_en_q;
  logic                      start;
  logic                      running;     // Read in progress
  logic                      hold_full;   // Holding register owns a word
  logic [byte_cnt_width-1:0] word_total;  // Words this read
  logic [byte_cnt_width-1:0] fetch_cnt;   // Words popped from the FIFO
  logic [byte_cnt_width-1:0] sent_cnt;    // Words taken by the host
  logic                      handoff;
  logic                      all_sent;

  assign start    = blk_en && !blk_en_q;
  assign rd_en    = blk_en && running && !hold_full && !fifo_empty &&
                    (fetch_cnt != word_total);
  assign handoff  = rdata_valid && rdata_ack;           // Host accepted
  assign all_sent = running && !hold_full && (sent_cnt == word_total);

  // --------------------
  // Read bookkeeping
  // --------------------
  always_ff @(posedge mem_clk) begin
    if (reset) begin
      blk_en_q   <= 1'b0;
      running    <= 1'b0;
      word_total <= '0;
      fetch_cnt  <= '0;
      sent_cnt   <= '0;
      read_end   <= 1'b0;
    end else begin
      blk_en_q <= blk_en;
      read_end <= 1'b0;
      if (start) begin
        running    <= 1'b1;
        word_total <= no_of_data_bytes >> 1;            // Two bytes per word
        fetch_cnt  <= '0;
        sent_cnt   <= '0;
      end else begin
        if (rd_en) begin
          fetch_cnt <= fetch_cnt + 1'b1;
        end
        if (handoff) begin
          sent_cnt <= sent_cnt + 1'b1;
        end
        if (all_sent && !rdata_ack && !read_end) begin
          read_end <= 1'b1;                             // Ack back low after last word
          running  <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // Four phase handshake
  // --------------------
  always_ff @(posedge mem_clk) begin
    if (reset) begin
      hold_full   <= 1'b0;
      rdata_valid <= 1'b0;
    end else begin
      if (rd_en) begin
        hold_full <= 1'b1;
      end else if (handoff) begin
        hold_full <= 1'b0;                              // Register free again
      end
      if (handoff) begin
        rdata_valid <= 1'b0;
      end else if (hold_full && !rdata_valid && !rdata_ack) begin
        rdata_valid <= 1'b1;                            // Only once ack has returned low
      end
    end
  end

  always_ff @(posedge mem_clk) begin
    if (rd_en) begin
      rdata <= fifo_dout;                               // Head word for the host
    end
  end

  // Memory pause request
  always_ff @(posedge mem_clk) begin
    if (reset) begin
      rd_clk_stretch <= 1'b0;
    end else begin
      rd_clk_stretch <= fifo_almost_full;
    end
  end

  a_byte_cnt_legal : assert property (
    @(posedge mem_clk) disable iff (reset)
      start |-> (!no_of_data_bytes[0] && (no_of_data_bytes != '0))
  ) else $error("rxdata_blk: byte count must be even and nonzero");

  // Host sees valid until it answers
  a_valid_held : assert property (
    @(posedge mem_clk) disable iff (reset) (rdata_valid && !rdata_ack) |=> rdata_valid
  ) else $error("rxdata_blk: valid dropped before ack");

endmodule

`default_nettype wire

/* verilog/rcvr_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rcvr_fsm (
  input  wire  mem_clk,
  input  wire  reset,
  input  wire  start_read,       // Single cycle pulse
  input  wire  instrn_dlp_en,    // Selects training on start
  input  wire  dlp_read_stop,
  input  wire  read_end,
  output logic training_blk_en,
  output logic rxdata_blk_en
);

  import read_engine_pkg::*;

  rcvr_state_t state;
  rcvr_state_t state_nxt;

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start_read) begin
          state_nxt = instrn_dlp_en ? st_train : st_data;
        end
      end
      st_train: begin
        if (dlp_read_stop) begin
          state_nxt = st_idle;     // Monitor finished
        end
      end
      st_data: begin
        if (read_end) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge mem_clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Grants decode straight from state
  assign training_blk_en = (state == st_train);
  assign rxdata_blk_en   = (state == st_data);

  a_one_owner : assert property (
    @(posedge mem_clk) disable iff (reset) !(training_blk_en && rxdata_blk_en)
  ) else $error("rcvr_fsm: both FIFO clients granted");

endmodule

`default_nettype wire

/* verilog/read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module read_engine (
  input  wire                                        mem_clk,
  input  wire                                        reset,
  input  wire                                        dqs,
  input  wire  [read_engine_pkg::dq_width-1:0]       dq_in,
  input  wire                                        start_read,
  input  wire                                        instrn_dlp_en,
  input  wire  [read_engine_pkg::dq_width-1:0]       instrn_dlp_pattern,
  input  wire  [read_engine_pkg::dlp_cnt_width-1:0]  csr_dlp_cyc_cnt,
  input  wire  [read_engine_pkg::byte_cnt_width-1:0] no_of_data_bytes,
  input  wire                                        rcv_dq_fifo_flush_en,
  input  wire                                        mem_16bit_rdata_ack,
  output logic [read_engine_pkg::word_width-1:0]     mem_16bit_rdata,
  output logic                                       mem_16bit_rdata_valid,
  output logic [read_engine_pkg::dq_width-1:0]       calib_tap_out,
  output logic                                       calib_tap_valid,
  output logic                                       dlp_read_stop,
  output logic                                       read_end,
  output logic                                       rcv_dqfifo_empty,
  output logic                                       rcv_dq_fifo_flush_done,
  output logic                                       rd_clk_stretch
);

  import read_engine_pkg::*;

  logic                  rcv_dqfifo_rd_en;
  logic [word_width-1:0] rcv_dqfifo_dout;
  logic                  rcv_dqfifo_almost_full;
  logic                  training_blk_en;
  logic                  rxdata_blk_en;
  logic                  training_rd_en;
  logic                  rxblk_rd_en;

  // --------------------
  // FIFO read port owner
  // --------------------
  assign rcv_dqfifo_rd_en = training_blk_en ? training_rd_en :
                            rxdata_blk_en   ? rxblk_rd_en    : 1'b0;

  rcv_dq_fifo #(.addr_width(rcv_fifo_addr_width)) rcv_dq_fifo_inst (
    .mem_clk     (mem_clk),
    .reset       (reset),
    .dqs         (dqs),
    .dq_in       (dq_in),
    .rd_en       (rcv_dqfifo_rd_en),
    .flush_en    (rcv_dq_fifo_flush_en),
    .dout        (rcv_dqfifo_dout),
    .empty       (rcv_dqfifo_empty),
    .almost_full (rcv_dqfifo_almost_full),
    .flush_done  (rcv_dq_fifo_flush_done)
  );

  training_monitor training_mon_inst (
    .mem_clk         (mem_clk),
    .reset           (reset),
    .blk_en          (training_blk_en),
    .dlp_pattern     (instrn_dlp_pattern),
    .dlp_cyc_cnt     (csr_dlp_cyc_cnt),
    .fifo_empty      (rcv_dqfifo_empty),
    .fifo_dout       (rcv_dqfifo_dout),
    .rd_en           (training_rd_en),
    .calib_tap_out   (calib_tap_out),
    .calib_tap_valid (calib_tap_valid),
    .dlp_read_stop   (dlp_read_stop)
  );

  rxdata_blk rxdata_blk_inst (
    .mem_clk          (mem_clk),
    .reset            (reset),
    .blk_en           (rxdata_blk_en),
    .no_of_data_bytes (no_of_data_bytes),
    .fifo_empty       (rcv_dqfifo_empty),
    .fifo_almost_full (rcv_dqfifo_almost_full),
    .fifo_dout        (rcv_dqfifo_dout),
    .rdata_ack        (mem_16bit_rdata_ack),
    .rd_en            (rxblk_rd_en),
    .rdata            (mem_16bit_rdata),
    .rdata_valid      (mem_16bit_rdata_valid),
    .read_end         (read_end),
    .rd_clk_stretch   (rd_clk_stretch)
  );

  rcvr_fsm rcvr_fsm_inst (
    .mem_clk         (mem_clk),
    .reset           (reset),
    .start_read      (start_read),
    .instrn_dlp_en   (instrn_dlp_en),
    .dlp_read_stop   (dlp_read_stop),
    .read_end        (read_end),
    .training_blk_en (training_blk_en),
    .rxdata_blk_en   (rxdata_blk_en)
  );

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter real period_ns = 10.0
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period_ns / 2.0) clk = ~clk;  // Free running

endmodule

`default_nettype wire

/* bench/tb_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_read_engine;

  logic        mem_clk;
  logic        reset;
  logic        dqs;
  logic [7:0]  dq_in;
  logic        start_read;
  logic        instrn_dlp_en;
  logic [7:0]  instrn_dlp_pattern;
  logic [2:0]  csr_dlp_cyc_cnt;
  logic [5:0]  no_of_data_bytes;
  logic        rcv_dq_fifo_flush_en;
  logic        mem_16bit_rdata_ack;
  logic [15:0] mem_16bit_rdata;
  logic        mem_16bit_rdata_valid;
  logic [7:0]  calib_tap_out;
  logic        calib_tap_valid;
  logic        dlp_read_stop;
  logic        read_end;
  logic        rcv_dqfifo_empty;
  logic        rcv_dq_fifo_flush_done;
  logic        rd_clk_stretch;

  // Stimulus and scoreboard state
  logic [7:0]  tx_bytes [0:63];    // Byte stream of the current read
  string       test_name = "reset";
  int          bytes_sent = 0;     // Sets the watchdog budget
  int          word_total = 0;     // Host words expected this read
  int          word_idx = 0;       // Host words seen this read
  int          read_end_cnt = 0;
  int          tap_valid_cnt = 0;
  int          stop_cnt = 0;
  logic        stretch_seen = 1'b0;
  int          ack_delay_min = 0;  // Zero means prompt ack
  int          ack_delay_max = 0;
  logic        prev_valid = 1'b0;
  logic        prev_ack = 1'b0;

  clk_gen clk_inst (.clk(mem_clk));

  read_engine dut (
    .mem_clk                (mem_clk),
    .reset                  (reset),
    .dqs                    (dqs),
    .dq_in                  (dq_in),
    .start_read             (start_read),
    .instrn_dlp_en          (instrn_dlp_en),
    .instrn_dlp_pattern     (instrn_dlp_pattern),
    .csr_dlp_cyc_cnt        (csr_dlp_cyc_cnt),
    .no_of_data_bytes       (no_of_data_bytes),
    .rcv_dq_fifo_flush_en   (rcv_dq_fifo_flush_en),
    .mem_16bit_rdata_ack    (mem_16bit_rdata_ack),
    .mem_16bit_rdata        (mem_16bit_rdata),
    .mem_16bit_rdata_valid  (mem_16bit_rdata_valid),
    .calib_tap_out          (calib_tap_out),
    .calib_tap_valid        (calib_tap_valid),
    .dlp_read_stop          (dlp_read_stop),
    .read_end               (read_end),
    .rcv_dqfifo_empty       (rcv_dqfifo_empty),
    .rcv_dq_fifo_flush_done (rcv_dq_fifo_flush_done),
    .rd_clk_stretch         (rd_clk_stretch)
  );

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [15:0] expected_word(input int idx);
    return {tx_bytes[2*idx], tx_bytes[2*idx+1]};  // First byte lands high
  endfunction

  function automatic logic [7:0] expected_tap(input logic [7:0] pattern, input int n);
    logic [7:0] err;
    err = 8'h00;
    for (int i = 0; i < n; i++) begin
      err = err | (tx_bytes[i] ^ pattern);  // Any miss kills the lane
    end
    return 8'hff & ~err;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("Fail %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
    end
  endtask

  // --------------------
  // Memory and host models
  // --------------------
  task automatic send_bytes(input int n);
    int i;
    bytes_sent += n;
    i = 0;
    while (i < n) begin
      @(posedge mem_clk);
      #1;
      if (!rd_clk_stretch) begin  // Memory pauses on stretch
        dq_in = tx_bytes[i];
        dqs   = ~dqs;             // One level change per byte
        i++;
      end
    end
  endtask

  always begin : host_ack
    int delay;
    @(posedge mem_clk);
    #1;
    if (mem_16bit_rdata_valid && !mem_16bit_rdata_ack) begin
      delay = (ack_delay_max > 0) ?
              ack_delay_min + ($urandom % (ack_delay_max - ack_delay_min + 1)) : 0;
      repeat (delay) begin
        @(posedge mem_clk);
        #1;
      end
      mem_16bit_rdata_ack = 1'b1;
    end else if (!mem_16bit_rdata_valid && mem_16bit_rdata_ack) begin
      mem_16bit_rdata_ack = 1'b0;  // Return to zero phase
    end
  end

  // Comparator, one word per valid and ack overlap
  always @(negedge mem_clk) begin : compare_words
    if (mem_16bit_rdata_valid && mem_16bit_rdata_ack) begin
      if (word_idx >= word_total) begin
        report_failure($sformatf("%s: host word 0x%0h arrived with no word pending",
                                 test_name, mem_16bit_rdata));
      end else begin
        check_value($sformatf("%s word %0d", test_name, word_idx),
                    expected_word(word_idx), mem_16bit_rdata);
        word_idx++;
      end
    end
  end

  // Pulse counters and handshake rule
  always @(negedge mem_clk) begin : watch_strobes
    if (read_end) read_end_cnt++;
    if (calib_tap_valid) tap_valid_cnt++;
    if (dlp_read_stop) stop_cnt++;
    if (rd_clk_stretch) stretch_seen = 1'b1;
    if (prev_valid && !prev_ack && !mem_16bit_rdata_valid) begin
      report_failure($sformatf("%s: valid dropped before the host answered", test_name));
    end
    prev_valid = mem_16bit_rdata_valid;
    prev_ack   = mem_16bit_rdata_ack;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 200 * bytes_sent + 1000) begin
      @(posedge mem_clk);
      cycles++;
    end
    report_failure($sformatf("Timeout in %s after %0d cycles, receiver state %0d",
                             test_name, cycles, dut.rcvr_fsm_inst.state));
  end

  // --------------------
  // Test tasks
  // --------------------
  task automatic start_pulse(input logic dlp);
    @(posedge mem_clk);
    #1;
    instrn_dlp_en = dlp;
    start_read    = 1'b1;
    @(posedge mem_clk);
    #1;
    start_read = 1'b0;
  endtask

  task automatic run_data_read(input string name, input int n, input logic slow_ack);
    test_name     = name;
    ack_delay_min = slow_ack ? 10 : 0;
    ack_delay_max = slow_ack ? 39 : 0;
    for (int i = 0; i < n; i++) tx_bytes[i] = $urandom;
    word_total   = n / 2;
    word_idx     = 0;
    read_end_cnt = 0;
    stretch_seen = 1'b0;
    @(posedge mem_clk);
    #1;
    no_of_data_bytes = n;
    start_pulse(1'b0);
    fork
      send_bytes(n);
      do @(negedge mem_clk); while (!read_end);  // Until the read closes
    join
    check_value({name, " word count"}, word_total, word_idx);
    repeat (2) @(negedge mem_clk);
    check_value({name, " read_end pulses"}, 1, read_end_cnt);
    if (slow_ack) check_value({name, " stretch seen"}, 1, stretch_seen);
  endtask

  task automatic run_dlp_read(input string name, input int n_faults);
    logic [7:0] pattern;
    logic [7:0] expected;
    int         n_bytes;
    int         fault_byte;
    int         fault_lane;
    pattern = $urandom;
    n_bytes = 2 * (1 + ($urandom % 8));
    test_name = name;
    for (int i = 0; i < n_bytes; i++) tx_bytes[i] = pattern;
    for (int f = 0; f < n_faults; f++) begin
      fault_byte = $urandom % n_bytes;
      fault_lane = $urandom % 8;
      tx_bytes[fault_byte] = tx_bytes[fault_byte] ^ (8'h01 << fault_lane);  // Single lane flip
    end
    expected      = expected_tap(pattern, n_bytes);
    word_total    = 0;
    word_idx      = 0;
    tap_valid_cnt = 0;
    stop_cnt      = 0;
    @(posedge mem_clk);
    #1;
    instrn_dlp_pattern = pattern;
    csr_dlp_cyc_cnt    = n_bytes / 2 - 1;
    start_pulse(1'b1);
    fork
      send_bytes(n_bytes);
      do @(negedge mem_clk); while (!calib_tap_valid);
    join
    check_value({name, " tap mask"}, expected, calib_tap_out);
    check_value({name, " stop with valid"}, 1, dlp_read_stop);
    check_value({name, " fifo drained"}, 1, rcv_dqfifo_empty);  // Every pattern word popped
    repeat (2) @(negedge mem_clk);
    check_value({name, " tap_valid pulses"}, 1, tap_valid_cnt);
    check_value({name, " stop pulses"}, 1, stop_cnt);
  endtask

  task automatic run_flush(input string name);
    test_name   = name;
    tx_bytes[0] = $urandom;
    send_bytes(1);                 // Odd byte left waiting
    @(posedge mem_clk);
    #1;
    rcv_dq_fifo_flush_en = 1'b1;
    @(negedge mem_clk);
    check_value({name, " done early"}, 0, rcv_dq_fifo_flush_done);
    check_value({name, " empty before"}, 1, rcv_dqfifo_empty);
    @(posedge mem_clk);
    #1;
    rcv_dq_fifo_flush_en = 1'b0;
    @(negedge mem_clk);
    check_value({name, " done"}, 1, rcv_dq_fifo_flush_done);
    check_value({name, " empty after"}, 1, rcv_dqfifo_empty);
    @(negedge mem_clk);
    check_value({name, " done width"}, 0, rcv_dq_fifo_flush_done);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    void'($urandom(44300));
    reset = 1'b1;
    dqs = 1'b0;
    dq_in = 8'h00;
    start_read = 1'b0;
    instrn_dlp_en = 1'b0;
    instrn_dlp_pattern = 8'h00;
    csr_dlp_cyc_cnt = 3'd0;
    no_of_data_bytes = 6'd0;
    rcv_dq_fifo_flush_en = 1'b0;
    mem_16bit_rdata_ack = 1'b0;
    repeat (10) @(posedge mem_clk);
    #1;
    reset = 1'b0;

    @(negedge mem_clk);
    check_value("reset valid", 0, mem_16bit_rdata_valid);
    check_value("reset tap_valid", 0, calib_tap_valid);
    check_value("reset dlp_stop", 0, dlp_read_stop);
    check_value("reset read_end", 0, read_end);
    check_value("reset flush_done", 0, rcv_dq_fifo_flush_done);
    check_value("reset stretch", 0, rd_clk_stretch);
    check_value("reset train_en", 0, dut.training_blk_en);
    check_value("reset data_en", 0, dut.rxdata_blk_en);
    check_value("reset empty", 1, rcv_dqfifo_empty);

    for (int i = 0; i < 4; i++) begin
      run_data_read($sformatf("data_prompt_%0d", i), 2 * (1 + ($urandom % 31)), 1'b0);
    end
    for (int i = 0; i < 2; i++) begin
      run_data_read($sformatf("data_slow_%0d", i), 2 * (20 + ($urandom % 12)), 1'b1);
    end
    run_dlp_read("dlp_clean", 0);
    for (int i = 0; i < 3; i++) begin
      run_dlp_read($sformatf("dlp_fault_%0d", i), 1 + ($urandom % 2));
    end
    run_flush("flush");
    run_data_read("data_after_flush", 2 * (1 + ($urandom % 31)), 1'b0);
    run_dlp_read("b2b_dlp_a", 1);
    run_data_read("b2b_data", 2 * (1 + ($urandom % 31)), 1'b0);
    run_dlp_read("b2b_dlp_b", 0);

    repeat (5) @(posedge mem_clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/read_engine_pkg.sv
verilog/rcv_dq_fifo.sv
verilog/training_monitor.sv
verilog/rxdata_blk.sv
verilog/rcvr_fsm.sv
verilog/read_engine.sv
bench/clk_gen.sv
bench/tb_read_engine.sv

/* Bender.yml */
package:
  name: read_engine

sources:
  - verilog/read_engine_pkg.sv
  - verilog/rcv_dq_fifo.sv
  - verilog/training_monitor.sv
  - verilog/rxdata_blk.sv
  - verilog/rcvr_fsm.sv
  - verilog/read_engine.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/tb_read_engine.sv
